// ==== design/fb_pkg.sv ====
package fb_pkg;

    // Pixel word layout, RGB565 with red on top
    localparam int PIX_W   = 16;
    localparam int RED_W   = 5;
    localparam int GREEN_W = 6;
    localparam int BLUE_W  = 5;

    // Host side word address
    localparam int ADDR_W = 22;

    // Default 640x480 raster timing
    localparam int DEF_H_ACTIVE = 640;
    localparam int DEF_H_FRONT  = 16;
    localparam int DEF_H_SYNC   = 96;
    localparam int DEF_H_BACK   = 48;

    localparam int DEF_V_ACTIVE = 480;
    localparam int DEF_V_FRONT  = 10;
    localparam int DEF_V_SYNC   = 2;
    localparam int DEF_V_BACK   = 33;

    localparam int DEF_QUEUE_DEPTH = 4;

    // Phases of one line or one frame, in scan order
    typedef enum logic [1:0] {
        ACTIVE,
        FRONT,
        SYNC,
        BACK
    } scan_phase_t;

endpackage

// ==== design/write_queue.sv ====
module write_queue
    import fb_pkg::*;
#(
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_valid,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [PIX_W-1:0]  wr_data,
    output logic              q_valid,
    output logic [ADDR_W-1:0] q_addr,
    output logic [PIX_W-1:0]  q_data,
    input  logic              q_pop,
    output logic              wr_credit
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [ADDR_W-1:0] addr_mem [QUEUE_DEPTH];
    logic [PIX_W-1:0]  data_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              push;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(QUEUE_DEPTH));
    assign push    = wr_valid && !full;
    assign q_valid = (count != '0);
    assign q_addr  = addr_mem[rd_ptr];
    assign q_data  = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= wr_addr;
            data_mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            wr_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (q_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per committed entry
            wr_credit <= q_pop;
        end
    end

    // Host spent a credit it did not hold
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) wr_valid |-> !full
    );

    // Frame store only takes an entry that exists
    a_pop_needs_entry: assert property (
        @(posedge clk) disable iff (!rst_n) q_pop |-> q_valid
    );

endmodule

// ==== design/frame_store.sv ====
module frame_store
    import fb_pkg::*;
#(
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int V_ACTIVE = DEF_V_ACTIVE
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              q_valid,
    input  logic [ADDR_W-1:0] q_addr,
    input  logic [PIX_W-1:0]  q_data,
    output logic              q_pop,
    input  logic              fetch_valid,
    input  logic [ADDR_W-1:0] fetch_addr,
    output logic [PIX_W-1:0]  rd_data
);

    localparam int DEPTH = H_ACTIVE * V_ACTIVE;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [PIX_W-1:0] mem [DEPTH];
    logic             in_range;

    // Scan owns the port while fetching and writes fill the gaps
    assign q_pop    = q_valid && !fetch_valid;
    assign in_range = (q_addr < ADDR_W'(DEPTH));

    // Single port with one read or one write per cycle
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            rd_data <= mem[fetch_addr[IDX_W-1:0]];
        end else if (q_pop && in_range) begin
            mem[q_addr[IDX_W-1:0]] <= q_data;
        end
    end

    // Raster never fetches past the end of the screen
    a_fetch_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) fetch_valid |-> fetch_addr < ADDR_W'(DEPTH)
    );

endmodule

// ==== design/raster_timing.sv ====
module raster_timing
    import fb_pkg::*;
#(
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int H_FRONT  = DEF_H_FRONT,
    parameter int H_SYNC   = DEF_H_SYNC,
    parameter int H_BACK   = DEF_H_BACK,
    parameter int V_ACTIVE = DEF_V_ACTIVE,
    parameter int V_FRONT  = DEF_V_FRONT,
    parameter int V_SYNC   = DEF_V_SYNC,
    parameter int V_BACK   = DEF_V_BACK
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic              fetch_valid,
    output logic [ADDR_W-1:0] fetch_addr,
    output logic              raw_hs,
    output logic              raw_vs,
    output logic              raw_de
);

    localparam int H_W = $clog2(H_ACTIVE + H_FRONT + H_SYNC + H_BACK);
    localparam int V_W = $clog2(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);

    scan_phase_t       h_phase;
    scan_phase_t       v_phase;
    logic [H_W-1:0]    h_cnt;
    logic [V_W-1:0]    v_cnt;
    int                h_len;
    int                v_len;
    logic              h_last;
    logic              v_last;
    logic              line_end;
    logic              frame_end;
    logic              pix_on;
    logic [ADDR_W-1:0] lin_addr;

    function automatic scan_phase_t next_phase(input scan_phase_t p);
        case (p)
            ACTIVE:  return FRONT;
            FRONT:   return SYNC;
            SYNC:    return BACK;
            default: return ACTIVE;
        endcase
    endfunction

    // Length of the current phase in pixels or lines
    always_comb begin
        case (h_phase)
            ACTIVE:  h_len = H_ACTIVE;
            FRONT:   h_len = H_FRONT;
            SYNC:    h_len = H_SYNC;
            default: h_len = H_BACK;
        endcase
        case (v_phase)
            ACTIVE:  v_len = V_ACTIVE;
            FRONT:   v_len = V_FRONT;
            SYNC:    v_len = V_SYNC;
            default: v_len = V_BACK;
        endcase
    end

    assign h_last    = (int'(h_cnt) == h_len - 1);
    assign v_last    = (int'(v_cnt) == v_len - 1);
    assign line_end  = h_last && (h_phase == BACK);
    assign frame_end = line_end && v_last && (v_phase == BACK);
    assign pix_on    = (h_phase == ACTIVE) && (v_phase == ACTIVE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_phase <= ACTIVE;
            h_cnt   <= '0;
            v_phase <= ACTIVE;
            v_cnt   <= '0;
        end else begin
            if (h_last) begin
                h_phase <= next_phase(h_phase);
                h_cnt   <= '0;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            // Vertical steps once per line
            if (line_end) begin
                if (v_last) begin
                    v_phase <= next_phase(v_phase);
                    v_cnt   <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end
        end
    end

    // Fetch strobe and raw sync registered in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
            raw_hs      <= 1'b1;
            raw_vs      <= 1'b1;
            lin_addr    <= '0;
        end else begin
            fetch_valid <= pix_on;
            raw_hs      <= (h_phase != SYNC);
            raw_vs      <= (v_phase != SYNC);
            if (frame_end) begin
                lin_addr <= '0;
            end else if (pix_on) begin
                lin_addr <= lin_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        fetch_addr <= lin_addr;
    end

    assign raw_de = fetch_valid;

endmodule

// ==== design/pixel_scanout.sv ====
module pixel_scanout
    import fb_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [PIX_W-1:0]   rd_data,
    input  logic               raw_hs,
    input  logic               raw_vs,
    input  logic               raw_de,
    output logic [RED_W-1:0]   vga_red,
    output logic [GREEN_W-1:0] vga_green,
    output logic [BLUE_W-1:0]  vga_blue,
    output logic               vga_hs,
    output logic               vga_vs,
    output logic               vga_de
);

    // First stage matches the memory read latency
    logic hs_d1;
    logic vs_d1;
    logic de_d1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_d1     <= 1'b1;
            vs_d1     <= 1'b1;
            de_d1     <= 1'b0;
            vga_hs    <= 1'b1;
            vga_vs    <= 1'b1;
            vga_de    <= 1'b0;
            vga_red   <= '0;
            vga_green <= '0;
            vga_blue  <= '0;
        end else begin
            hs_d1  <= raw_hs;
            vs_d1  <= raw_vs;
            de_d1  <= raw_de;
            vga_hs <= hs_d1;
            vga_vs <= vs_d1;
            vga_de <= de_d1;
            // Blank outside the visible window
            if (de_d1) begin
                vga_red   <= rd_data[PIX_W-1 -: RED_W];
                vga_green <= rd_data[BLUE_W +: GREEN_W];
                vga_blue  <= rd_data[BLUE_W-1:0];
            end else begin
                vga_red   <= '0;
                vga_green <= '0;
                vga_blue  <= '0;
            end
        end
    end

endmodule

// ==== design/vga_frame_top.sv ====
module vga_frame_top
    import fb_pkg::*;
#(
    parameter int H_ACTIVE    = DEF_H_ACTIVE,
    parameter int H_FRONT     = DEF_H_FRONT,
    parameter int H_SYNC      = DEF_H_SYNC,
    parameter int H_BACK      = DEF_H_BACK,
    parameter int V_ACTIVE    = DEF_V_ACTIVE,
    parameter int V_FRONT     = DEF_V_FRONT,
    parameter int V_SYNC      = DEF_V_SYNC,
    parameter int V_BACK      = DEF_V_BACK,
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_valid,
    input  logic [ADDR_W-1:0]  wr_addr,
    input  logic [PIX_W-1:0]   wr_data,
    output logic               wr_credit,
    output logic               lock,
    output logic [RED_W-1:0]   vga_red,
    output logic [GREEN_W-1:0] vga_green,
    output logic [BLUE_W-1:0]  vga_blue,
    output logic               vga_hs,
    output logic               vga_vs,
    output logic               vga_de
);

    logic              q_valid;
    logic [ADDR_W-1:0] q_addr;
    logic [PIX_W-1:0]  q_data;
    logic              q_pop;
    logic [ADDR_W-1:0] fetch_addr;
    logic [PIX_W-1:0]  rd_data;
    logic              raw_hs;
    logic              raw_vs;
    logic              raw_de;

    write_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) write_queue_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .q_valid   (q_valid),
        .q_addr    (q_addr),
        .q_data    (q_data),
        .q_pop     (q_pop),
        .wr_credit (wr_credit)
    );

    // The fetch strobe doubles as the memory lock seen by the host
    frame_store #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) frame_store_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .q_valid     (q_valid),
        .q_addr      (q_addr),
        .q_data      (q_data),
        .q_pop       (q_pop),
        .fetch_valid (lock),
        .fetch_addr  (fetch_addr),
        .rd_data     (rd_data)
    );

    raster_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) raster_timing_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (lock),
        .fetch_addr  (fetch_addr),
        .raw_hs      (raw_hs),
        .raw_vs      (raw_vs),
        .raw_de      (raw_de)
    );

    pixel_scanout pixel_scanout_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_data   (rd_data),
        .raw_hs    (raw_hs),
        .raw_vs    (raw_vs),
        .raw_de    (raw_de),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .vga_hs    (vga_hs),
        .vga_vs    (vga_vs),
        .vga_de    (vga_de)
    );

endmodule

// ==== dv/tb_vga_frame.sv ====
module tb_vga_frame
    import fb_pkg::*;
;

    localparam int H_ACTIVE     = 16;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 3;
    localparam int H_BACK       = 2;
    localparam int V_ACTIVE     = 8;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;
    localparam int QUEUE_DEPTH  = 4;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 4;
    localparam int SEED         = 35312;
    localparam int NPIX         = H_ACTIVE * V_ACTIVE;
    localparam int LINE_CYCLES  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int FRAME_LINES  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
    localparam int RANDOM_ROW   = 5;
    localparam int BURST_WRITES = 200;

    logic               clk;
    logic               rst_n;
    logic               wr_valid;
    logic [ADDR_W-1:0]  wr_addr;
    logic [PIX_W-1:0]   wr_data;
    logic               wr_credit;
    logic               lock;
    logic [RED_W-1:0]   vga_red;
    logic [GREEN_W-1:0] vga_green;
    logic [BLUE_W-1:0]  vga_blue;
    logic               vga_hs;
    logic               vga_vs;
    logic               vga_de;

    // Expected screen and the last captured screen
    logic [PIX_W-1:0] exp_frame [NPIX];
    logic [PIX_W-1:0] got_frame [NPIX];
    int               credits;
    int               seed_sink;
    logic             lock_q;

    vga_frame_top #(
        .H_ACTIVE    (H_ACTIVE),
        .H_FRONT     (H_FRONT),
        .H_SYNC      (H_SYNC),
        .H_BACK      (H_BACK),
        .V_ACTIVE    (V_ACTIVE),
        .V_FRONT     (V_FRONT),
        .V_SYNC      (V_SYNC),
        .V_BACK      (V_BACK),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) vga_frame_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_credit (wr_credit),
        .lock      (lock),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .vga_hs    (vga_hs),
        .vga_vs    (vga_vs),
        .vga_de    (vga_de)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic fail_test(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Stopped at first error");
    endtask

    // Host credit count and lock rule checked on each falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            lock_q = 1'b0;
        end else begin
            if (wr_credit) begin
                if (lock_q) begin
                    fail_test("Credit returned right after a locked cycle, write committed during scan");
                end
                credits = credits + 1;
            end
            if (credits < 0 || credits > QUEUE_DEPTH) begin
                fail_test("Host credit count left the range 0 to queue depth");
            end
            lock_q = lock;
        end
    end

    task automatic to_drive_point;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Holds wr_valid for one cycle from a drive point
    task automatic issue_write(input logic [ADDR_W-1:0] addr, input logic [PIX_W-1:0] data);
        while (credits == 0) begin
            to_drive_point();
        end
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        credits  = credits - 1;
        if (addr < NPIX) begin
            exp_frame[addr] = data;
        end
        to_drive_point();
        wr_valid = 1'b0;
    endtask

    task automatic wait_drain;
        int cycles;
        cycles = 0;
        while (credits != QUEUE_DEPTH) begin
            to_drive_point();
            cycles++;
            if (cycles > 2 * FRAME_CYCLES) begin
                fail_test("Write queue did not drain, credits never came back");
            end
        end
    endtask

    task automatic wait_vs_fall;
        logic prev;
        do begin
            prev = vga_vs;
            @(negedge clk);
        end while (!(prev && !vga_vs));
    endtask

    task automatic collect_frame;
        int n;
        n = 0;
        wait_vs_fall();
        while (n < NPIX) begin
            @(negedge clk);
            if (vga_de) begin
                got_frame[n] = {vga_red, vga_green, vga_blue};
                n++;
            end
        end
    endtask

    task automatic compare_frame;
        for (int i = 0; i < NPIX; i++) begin
            check_value($sformatf("vga_red pixel %0d", i),
                        exp_frame[i][15:11], got_frame[i][15:11]);
            check_value($sformatf("vga_green pixel %0d", i),
                        exp_frame[i][10:5], got_frame[i][10:5]);
            check_value($sformatf("vga_blue pixel %0d", i),
                        exp_frame[i][4:0], got_frame[i][4:0]);
        end
    endtask

    task automatic check_idle_outputs;
        check_value("vga_hs", 1, vga_hs);
        check_value("vga_vs", 1, vga_vs);
        check_value("vga_de", 0, vga_de);
        check_value("lock", 0, lock);
        check_value("wr_credit", 0, wr_credit);
        check_value("vga_red", 0, vga_red);
        check_value("vga_green", 0, vga_green);
        check_value("vga_blue", 0, vga_blue);
    endtask

    task automatic test_reset_state;
        rst_n = 1'b0;
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            check_idle_outputs();
        end
        to_drive_point();
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        // Raster opens on pixel (0, 0) and video follows two cycles later
        @(negedge clk);
        check_value("lock", 1, lock);
        check_value("vga_de", 0, vga_de);
        @(negedge clk);
        check_value("vga_de", 0, vga_de);
        @(negedge clk);
        check_value("vga_de", 1, vga_de);
    endtask

    task automatic test_raster_geometry;
        int de_run;
        int hs_run;
        int vs_run;
        int lines;
        int hs_pulses;
        wait_vs_fall();
        de_run    = 0;
        hs_run    = 0;
        vs_run    = 1;
        lines     = 0;
        hs_pulses = 0;
        repeat (FRAME_CYCLES - 1) begin
            @(negedge clk);
            if (vga_de) begin
                de_run++;
            end else begin
                if (de_run != 0) begin
                    check_value("vga_de pixels per line", H_ACTIVE, de_run);
                    lines++;
                    de_run = 0;
                end
                check_value("vga_red blank", 0, vga_red);
                check_value("vga_green blank", 0, vga_green);
                check_value("vga_blue blank", 0, vga_blue);
            end
            if (!vga_hs) begin
                hs_run++;
            end else if (hs_run != 0) begin
                check_value("vga_hs low cycles", H_SYNC, hs_run);
                hs_pulses++;
                hs_run = 0;
            end
            if (!vga_vs) begin
                vs_run++;
            end else if (vs_run != 0) begin
                check_value("vga_vs low cycles", V_SYNC * LINE_CYCLES, vs_run);
                vs_run = 0;
            end
        end
        check_value("vga_de lines per frame", V_ACTIVE, lines);
        check_value("vga_hs pulses per frame", FRAME_LINES, hs_pulses);
    endtask

    task automatic test_frame_contents;
        logic [PIX_W-1:0] data;
        to_drive_point();
        for (int y = 0; y < V_ACTIVE; y++) begin
            for (int x = 0; x < H_ACTIVE; x++) begin
                if (y == RANDOM_ROW) begin
                    data = PIX_W'($urandom);
                end else if ((x % 2) != (y % 2)) begin
                    data = 16'hFFFF;
                end else begin
                    data = PIX_W'(y);
                end
                issue_write(ADDR_W'(y * H_ACTIVE + x), data);
            end
        end
        wait_drain();
        collect_frame();
        compare_frame();
    endtask

    task automatic test_credit_accounting;
        to_drive_point();
        for (int i = 0; i < BURST_WRITES; i++) begin
            issue_write(ADDR_W'((i * 7) % NPIX), PIX_W'((i * 291) ^ 23130));
        end
        wait_drain();
        // Queue is empty so no stray credit may follow
        repeat (LINE_CYCLES) begin
            @(negedge clk);
            check_value("wr_credit", 0, wr_credit);
        end
    endtask

    task automatic test_lock_rule;
        logic saw_unlock;
        wait_drain();
        // Find the start of an active line
        do begin
            @(negedge clk);
        end while (lock);
        do begin
            @(negedge clk);
        end while (!lock);
        to_drive_point();
        issue_write(ADDR_W'(3 * H_ACTIVE + 2), 16'h07E0);
        check_value("lock", 1, lock);
        saw_unlock = 1'b0;
        do begin
            @(negedge clk);
            if (!lock) begin
                saw_unlock = 1'b1;
            end
        end while (!wr_credit);
        if (!saw_unlock) begin
            fail_test("Write issued during an active line returned its credit before lock fell");
        end
    endtask

    task automatic test_overwrite_range;
        to_drive_point();
        issue_write(ADDR_W'(2 * H_ACTIVE + 9), 16'h1234);
        issue_write(ADDR_W'(2 * H_ACTIVE + 9), 16'hBEEF);
        // Writes beyond the screen leave every pixel alone
        issue_write(ADDR_W'(NPIX + 3), 16'h0F0F);
        issue_write({ADDR_W{1'b1}}, 16'hF0F0);
        wait_drain();
        collect_frame();
        compare_frame();
    endtask

    initial begin
        seed_sink = $urandom(SEED);
        credits   = QUEUE_DEPTH;
        lock_q    = 1'b0;
        rst_n     = 1'b0;
        wr_valid  = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        test_reset_state();
        test_raster_geometry();
        test_frame_contents();
        test_credit_accounting();
        test_lock_rule();
        test_overwrite_range();
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #(12 * FRAME_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, tests did not finish within 12 frame periods");
        $display("=== FAIL ===");
        $fatal(1, "Timeout");
    end

endmodule

// ==== compile.f ====
design/fb_pkg.sv
design/write_queue.sv
design/frame_store.sv
design/raster_timing.sv
design/pixel_scanout.sv
design/vga_frame_top.sv
dv/tb_vga_frame.sv

// ==== Bender.yml ====
package:
  name: vga_frame

sources:
  - files:
      - design/fb_pkg.sv
      - design/write_queue.sv
      - design/frame_store.sv
      - design/raster_timing.sv
      - design/pixel_scanout.sv
      - design/vga_frame_top.sv
  - target: test
    files:
      - dv/tb_vga_frame.sv
